// File: common/wfd_channel_pkg.sv
`default_nettype none

package wfd_channel_pkg;

  ///////////////////////////////////////////////////////////////////////
  // widths
  localparam int LINK_WIDTH  = 32;   // serial link word
  localparam int BURST_WIDTH = 128;  // one DDR3 read burst
  localparam int FILL_WIDTH  = 24;   // fill number counter

  localparam int WORDS_PER_BURST = BURST_WIDTH / LINK_WIDTH;  // 4 link words per burst

  ///////////////////////////////////////////////////////////////////////
  // timing
  localparam int PAUSE_SYNC_STAGES = 2;   // flops on readout_pause
  localparam int LONG_RESET_CYCLES = 32;  // master pulse at least this long -> full reset
  localparam int FULL_RESET_CYCLES = 8;   // length of the full datapath reset

  // counter widths derived from the timing above
  localparam int WORD_IDX_W = $clog2(WORDS_PER_BURST);
  localparam int RST_CNT_W  = $clog2(LONG_RESET_CYCLES + 1);
  localparam int HOLD_CNT_W = $clog2(FULL_RESET_CYCLES);

  ///////////////////////////////////////////////////////////////////////
  // vector types
  typedef logic [LINK_WIDTH-1:0]  link_word_t;   // one link word
  typedef logic [BURST_WIDTH-1:0] mem_burst_t;   // one memory burst
  typedef logic [FILL_WIDTH-1:0]  fill_num_t;    // completed fill count
  typedef logic [WORD_IDX_W-1:0]  word_idx_t;    // word position inside a burst
  typedef logic [RST_CNT_W-1:0]   rst_cnt_t;     // master pulse length
  typedef logic [HOLD_CNT_W-1:0]  hold_cnt_t;    // full reset countdown

  ///////////////////////////////////////////////////////////////////////
  // state machines
  typedef enum logic [1:0] {
    CMD_IDLE,     // no command packet open
    CMD_BUSY,     // command packet started, waiting for its tlast
    READOUT,      // link owned by the fill readout
    READOUT_END   // one cycle after the last readout word, fill_done
  } source_state_t;

  typedef enum logic [1:0] {
    WAIT_HIGH,    // master line idle
    MEASURE,      // counting how long the line stays high
    HOLD_FULL     // driving the full datapath reset
  } reset_state_t;

endpackage

`default_nettype wire

// File: design/readout/readout_width_converter.sv
`timescale 1ns/1ns
`default_nettype none

// 128-bit memory bursts in, 32-bit link words out, low word first

module readout_width_converter (
  input  logic                       clk125,
  input  logic                       reset,
  // burst side, from the memory reader
  input  wfd_channel_pkg::mem_burst_t rd_tdata,
  input  logic                       rd_tvalid,
  input  logic                       rd_tlast,
  output logic                       rd_tready,
  // word side, toward the tx mux
  output wfd_channel_pkg::link_word_t word_tdata,
  output logic                       word_tvalid,
  output logic                       word_tlast,
  input  logic                       word_tready
);

  wfd_channel_pkg::mem_burst_t burst_q;   // holding register for one burst
  wfd_channel_pkg::word_idx_t  idx_q;     // which word goes out next
  logic                        full_q;    // burst_q holds unsent words
  logic                        last_q;    // held burst closes the fill
  logic                        accept_en; // opens rd_tready once out of reset

  logic word_xfer;    // a word leaves this cycle
  logic final_word;   // the word at idx_q is the top one of the burst
  logic burst_xfer;   // a new burst is taken this cycle

  assign final_word = (idx_q == wfd_channel_pkg::word_idx_t'(wfd_channel_pkg::WORDS_PER_BURST - 1));
  assign word_xfer  = word_tvalid & word_tready;
  // room when empty or when the top word is leaving right now (no bubble)
  assign rd_tready  = accept_en & (~full_q | (word_xfer & final_word));
  assign burst_xfer = rd_tvalid & rd_tready;

  ///////////////////////////////////////////////////////////////////////
  // word select
  assign word_tvalid = full_q;
  assign word_tdata  = burst_q[idx_q*wfd_channel_pkg::LINK_WIDTH +: wfd_channel_pkg::LINK_WIDTH];
  assign word_tlast  = full_q & last_q & final_word;  // tlast only on word 3

  ///////////////////////////////////////////////////////////////////////
  // control
  always_ff @(posedge clk125) begin
    if (reset) begin
      full_q    <= 1'b0;
      idx_q     <= '0;
      last_q    <= 1'b0;
      accept_en <= 1'b0;
    end else begin
      accept_en <= 1'b1;
      if (burst_xfer) begin          // takes priority to cover the back-to-back case
        full_q <= 1'b1;
        idx_q  <= '0;
        last_q <= rd_tlast;
      end else if (word_xfer) begin
        if (final_word) begin
          full_q <= 1'b0;            // burst fully sent
        end
        idx_q <= idx_q + 1'b1;       // wraps to 0 after word 3
      end
    end
  end

  // payload loads on acceptance only
  always_ff @(posedge clk125) begin
    if (burst_xfer) begin
      burst_q <= rd_tdata;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // a stalled word must not change under the link
  assert property (@(posedge clk125) disable iff (reset)
    (word_tvalid & ~word_tready) |=> $stable(word_tdata))
    else $error("word_tdata changed while stalled");

endmodule

`default_nettype wire

// File: design/readout/fill_readout_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

// decides who owns the link; only switches between whole packets

module fill_readout_arbiter (
  input  logic                       clk125,
  input  logic                       reset,
  input  logic                       evt_cnt_reset,        // short master reset, clears fill_num
  input  logic                       readout_req,          // level, held until fill_done
  input  logic                       cmd_accept,           // command word went out
  input  logic                       cmd_accept_last,      // ... and it was the packet end
  input  logic                       readout_accept,       // readout word went out
  input  logic                       readout_accept_last,  // ... and it closed the fill
  output logic                       use_readout,
  output logic                       fill_done,
  output wfd_channel_pkg::fill_num_t fill_num
);

  wfd_channel_pkg::source_state_t state_q, state_d;

  logic cmd_open;   // a command word without tlast just went out

  assign cmd_open = cmd_accept & ~cmd_accept_last;

  ///////////////////////////////////////////////////////////////////////
  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      wfd_channel_pkg::CMD_IDLE: begin
        if (cmd_open) begin
          state_d = wfd_channel_pkg::CMD_BUSY;      // packet started, stay on commands
        end else if (readout_req) begin
          state_d = wfd_channel_pkg::READOUT;       // boundary, hand over
        end
      end
      wfd_channel_pkg::CMD_BUSY: begin
        if (cmd_accept_last) begin
          if (readout_req) begin
            state_d = wfd_channel_pkg::READOUT;     // switch right at the tlast
          end else begin
            state_d = wfd_channel_pkg::CMD_IDLE;
          end
        end
      end
      wfd_channel_pkg::READOUT: begin
        if (readout_accept_last) begin
          state_d = wfd_channel_pkg::READOUT_END;
        end
      end
      wfd_channel_pkg::READOUT_END: begin
        // commands may move again here; readout_req is still up from this fill
        if (cmd_open) begin
          state_d = wfd_channel_pkg::CMD_BUSY;
        end else begin
          state_d = wfd_channel_pkg::CMD_IDLE;
        end
      end
      default: state_d = wfd_channel_pkg::CMD_IDLE;
    endcase
  end

  always_ff @(posedge clk125) begin
    if (reset) begin
      state_q <= wfd_channel_pkg::CMD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign use_readout = (state_q == wfd_channel_pkg::READOUT);
  assign fill_done   = (state_q == wfd_channel_pkg::READOUT_END);  // one cycle per fill

  ///////////////////////////////////////////////////////////////////////
  // fill counter, steps on the same edge that drops use_readout
  always_ff @(posedge clk125) begin
    if (reset || evt_cnt_reset) begin
      fill_num <= '0;
    end else if (state_q == wfd_channel_pkg::READOUT && readout_accept_last) begin
      fill_num <= fill_num + 1'b1;
    end
  end

  // the mux must never let readout data through without ownership
  assert property (@(posedge clk125) disable iff (reset)
    readout_accept |-> use_readout)
    else $error("readout word accepted while use_readout low");

endmodule

`default_nettype wire

// File: design/tx_stream_mux.sv
`timescale 1ns/1ns
`default_nettype none

// 2:1 combinational stream mux toward the link gated by readout_pause

module tx_stream_mux (
  input  logic                       clk125,
  input  logic                       reset,
  input  logic                       readout_pause,  // async from the master
  input  logic                       use_readout,    // from the arbiter
  // command source
  input  wfd_channel_pkg::link_word_t cmd_tdata,
  input  logic                       cmd_tvalid,
  input  logic                       cmd_tlast,
  output logic                       cmd_tready,
  // readout source
  input  wfd_channel_pkg::link_word_t word_tdata,
  input  logic                       word_tvalid,
  input  logic                       word_tlast,
  output logic                       word_tready,
  // link
  output wfd_channel_pkg::link_word_t tx_tdata,
  output logic                       tx_tvalid,
  output logic                       tx_tlast,
  input  logic                       tx_tready,
  // accepted-word reports for the arbiter
  output logic                       cmd_accept,
  output logic                       cmd_accept_last,
  output logic                       readout_accept,
  output logic                       readout_accept_last
);

  logic [wfd_channel_pkg::PAUSE_SYNC_STAGES-1:0] pause_sync;  // shift in at bit 0
  logic pause_q;      // synchronized pause
  logic link_ready;   // link can take a word this cycle

  ///////////////////////////////////////////////////////////////////////
  // pause synchronizer starts out of reset as paused
  always_ff @(posedge clk125) begin
    if (reset) begin
      pause_sync <= '1;
    end else begin
      pause_sync <= {pause_sync[wfd_channel_pkg::PAUSE_SYNC_STAGES-2:0], readout_pause};
    end
  end

  assign pause_q    = pause_sync[wfd_channel_pkg::PAUSE_SYNC_STAGES-1];
  assign link_ready = tx_tready & ~pause_q;

  ///////////////////////////////////////////////////////////////////////
  // steering
  assign tx_tdata  = use_readout ? word_tdata : cmd_tdata;
  assign tx_tlast  = use_readout ? word_tlast : cmd_tlast;
  assign tx_tvalid = ~pause_q & (use_readout ? word_tvalid : cmd_tvalid);

  assign word_tready = use_readout & link_ready;    // inactive side sees ready low
  assign cmd_tready  = ~use_readout & link_ready;

  assign cmd_accept          = cmd_tvalid & cmd_tready;
  assign cmd_accept_last     = cmd_accept & cmd_tlast;
  assign readout_accept      = word_tvalid & word_tready;
  assign readout_accept_last = readout_accept & word_tlast;

  // a pause held through the whole synchronizer blanks the link
  assert property (@(posedge clk125) disable iff (reset)
    readout_pause [*wfd_channel_pkg::PAUSE_SYNC_STAGES] |=> ~tx_tvalid)
    else $error("tx_tvalid high during readout pause");

endmodule

`default_nettype wire

// File: design/master_reset.sv
`timescale 1ns/1ns
`default_nettype none

// short master pulse -> clear fill counter, long pulse -> full datapath reset

module master_reset (
  input  logic clk125,
  input  logic reset,
  input  logic rst_from_master,  // async from the master
  output logic datapath_reset,
  output logic evt_cnt_reset
);

  logic mstr_meta, mstr_sync;                 // 2 flop synchronizer
  wfd_channel_pkg::reset_state_t state_q;
  wfd_channel_pkg::rst_cnt_t     high_cnt;    // clocks the line has been high, saturates
  wfd_channel_pkg::hold_cnt_t    hold_cnt;    // remaining full reset clocks
  logic                          is_long;     // pulse reached LONG_RESET_CYCLES

  always_ff @(posedge clk125) begin
    mstr_meta <= rst_from_master;
    mstr_sync <= mstr_meta;
  end

  assign is_long = (high_cnt >= wfd_channel_pkg::rst_cnt_t'(wfd_channel_pkg::LONG_RESET_CYCLES));

  ///////////////////////////////////////////////////////////////////////
  // pulse measurement
  always_ff @(posedge clk125) begin
    if (reset) begin
      state_q       <= wfd_channel_pkg::WAIT_HIGH;
      high_cnt      <= '0;
      hold_cnt      <= '0;
      evt_cnt_reset <= 1'b0;
    end else begin
      evt_cnt_reset <= 1'b0;                  // single cycle unless set below
      case (state_q)
        wfd_channel_pkg::WAIT_HIGH: begin
          if (mstr_sync) begin
            state_q  <= wfd_channel_pkg::MEASURE;
            high_cnt <= wfd_channel_pkg::rst_cnt_t'(1);
          end
        end
        wfd_channel_pkg::MEASURE: begin
          if (mstr_sync) begin
            if (!is_long) high_cnt <= high_cnt + 1'b1;
          end else if (is_long) begin         // released after a long pulse
            state_q  <= wfd_channel_pkg::HOLD_FULL;
            hold_cnt <= wfd_channel_pkg::hold_cnt_t'(wfd_channel_pkg::FULL_RESET_CYCLES - 1);
          end else begin                      // short pulse
            state_q       <= wfd_channel_pkg::WAIT_HIGH;
            evt_cnt_reset <= 1'b1;
          end
        end
        wfd_channel_pkg::HOLD_FULL: begin
          if (hold_cnt == '0) begin
            state_q <= wfd_channel_pkg::WAIT_HIGH;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        default: state_q <= wfd_channel_pkg::WAIT_HIGH;
      endcase
    end
  end

  // board reset also holds the datapath
  assign datapath_reset = reset | (state_q == wfd_channel_pkg::HOLD_FULL);

endmodule

`default_nettype wire

// File: design/channel_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

// transmit side of one digitizer channel, commands and fill readout onto one link

module channel_tx_top (
  input  logic                       clk125,
  input  logic                       reset,
  input  logic                       readout_req,
  input  logic                       readout_pause,
  input  logic                       rst_from_master,
  // command replies
  input  wfd_channel_pkg::link_word_t cmd_tdata,
  input  logic                       cmd_tvalid,
  input  logic                       cmd_tlast,
  output logic                       cmd_tready,
  // memory readout bursts
  input  wfd_channel_pkg::mem_burst_t rd_tdata,
  input  logic                       rd_tvalid,
  input  logic                       rd_tlast,
  output logic                       rd_tready,
  // serial link
  output wfd_channel_pkg::link_word_t tx_tdata,
  output logic                       tx_tvalid,
  output logic                       tx_tlast,
  input  logic                       tx_tready,
  // fill status
  output logic                       fill_done,
  output wfd_channel_pkg::fill_num_t fill_num
);

  logic datapath_reset;   // board reset or long master pulse
  logic evt_cnt_reset;    // short master pulse

  wfd_channel_pkg::link_word_t word_tdata;  // converter -> mux
  logic word_tvalid, word_tlast, word_tready;

  logic use_readout;
  logic cmd_accept, cmd_accept_last;
  logic readout_accept, readout_accept_last;

  ///////////////////////////////////////////////////////////////////////
  // resets from the master
  master_reset u_master_reset (
    .clk125          (clk125),
    .reset           (reset),
    .rst_from_master (rst_from_master),
    .datapath_reset  (datapath_reset),
    .evt_cnt_reset   (evt_cnt_reset)
  );

  ///////////////////////////////////////////////////////////////////////
  // readout path and source selection, side by side
  readout_width_converter u_width_conv (
    .clk125      (clk125),
    .reset       (datapath_reset),
    .rd_tdata    (rd_tdata),
    .rd_tvalid   (rd_tvalid),
    .rd_tlast    (rd_tlast),
    .rd_tready   (rd_tready),
    .word_tdata  (word_tdata),
    .word_tvalid (word_tvalid),
    .word_tlast  (word_tlast),
    .word_tready (word_tready)
  );

  fill_readout_arbiter u_arbiter (
    .clk125              (clk125),
    .reset               (datapath_reset),
    .evt_cnt_reset       (evt_cnt_reset),
    .readout_req         (readout_req),
    .cmd_accept          (cmd_accept),
    .cmd_accept_last     (cmd_accept_last),
    .readout_accept      (readout_accept),
    .readout_accept_last (readout_accept_last),
    .use_readout         (use_readout),
    .fill_done           (fill_done),
    .fill_num            (fill_num)
  );

  ///////////////////////////////////////////////////////////////////////
  // link mux
  tx_stream_mux u_tx_mux (
    .clk125              (clk125),
    .reset               (datapath_reset),
    .readout_pause       (readout_pause),
    .use_readout         (use_readout),
    .cmd_tdata           (cmd_tdata),
    .cmd_tvalid          (cmd_tvalid),
    .cmd_tlast           (cmd_tlast),
    .cmd_tready          (cmd_tready),
    .word_tdata          (word_tdata),
    .word_tvalid         (word_tvalid),
    .word_tlast          (word_tlast),
    .word_tready         (word_tready),
    .tx_tdata            (tx_tdata),
    .tx_tvalid           (tx_tvalid),
    .tx_tlast            (tx_tlast),
    .tx_tready           (tx_tready),
    .cmd_accept          (cmd_accept),
    .cmd_accept_last     (cmd_accept_last),
    .readout_accept      (readout_accept),
    .readout_accept_last (readout_accept_last)
  );

endmodule

`default_nettype wire

// File: dv/channel_tx_tb.sv
`timescale 1ns/1ns
`default_nettype none

// file driven testbench for channel_tx_top with a scoreboard built from the link rules

module channel_tx_tb;

  logic                        clk125;
  logic                        reset;
  logic                        readout_req, readout_pause, rst_from_master;
  wfd_channel_pkg::link_word_t cmd_tdata;
  logic                        cmd_tvalid, cmd_tlast, cmd_tready;
  wfd_channel_pkg::mem_burst_t rd_tdata;
  logic                        rd_tvalid, rd_tlast, rd_tready;
  wfd_channel_pkg::link_word_t tx_tdata;
  logic                        tx_tvalid, tx_tlast, tx_tready;
  logic                        fill_done;
  wfd_channel_pkg::fill_num_t  fill_num;

  integer seed;
  int     cycles;
  int     limit;
  wfd_channel_pkg::link_word_t exp_data[$];   // expected link words in order
  logic                        exp_last[$];
  logic                        exp_end[$];    // word closes a fill readout
  logic                        fill_due;      // fill_done expected this cycle
  byte         op_code[$];                    // parsed test file
  logic [31:0] op_a[$], op_b[$], op_c[$], op_d[$];

  channel_tx_top dut (.*);

  initial begin
    clk125 = 1'b0;
    forever #5 clk125 = ~clk125;
  end

  ///////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input wfd_channel_pkg::link_word_t got, input logic got_last,
                            input wfd_channel_pkg::link_word_t exp, input logic exp_last_b);
    if (got !== exp || got_last !== exp_last_b) begin
      $display("[FAIL] %0t ns: link word %h last %b, expected %h last %b",
               $time, got, got_last, exp, exp_last_b);
      $display("TESTS FAILED");
      $fatal(1, "link word mismatch");
    end
  endtask

  task automatic check_fill(input wfd_channel_pkg::fill_num_t got,
                            input wfd_channel_pkg::fill_num_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: fill_num %0d, expected %0d", $time, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "fill_num mismatch");
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: tx_tvalid %b, expected %b", $time, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "tx_tvalid mismatch");
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: fill_done %b, expected %b", $time, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "fill_done mismatch");
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // expected words from the stream rules
  task automatic expect_cmd(input int n, input logic [31:0] first);
    for (int i = 0; i < n; i++) begin
      exp_data.push_back(first + i);   // commands pass unchanged
      exp_last.push_back(i == n - 1);
      exp_end.push_back(1'b0);
    end
  endtask

  task automatic expect_fill(input int n, input logic [31:0] first);
    for (int i = 0; i < 4 * n; i++) begin
      exp_data.push_back(first + i);   // low word of each burst first
      exp_last.push_back(i == 4 * n - 1);
      exp_end.push_back(i == 4 * n - 1);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // stream drivers change inputs on the falling edge only
  task automatic send_cmd(input int n, input logic [31:0] first);
    for (int i = 0; i < n; i++) begin
      @(negedge clk125);
      cmd_tvalid = 1'b1;
      cmd_tdata  = first + i;
      cmd_tlast  = (i == n - 1);
      do @(posedge clk125); while (!cmd_tready);
    end
    @(negedge clk125);
    cmd_tvalid = 1'b0;
  endtask

  task automatic send_fill(input int n, input logic [31:0] first);
    for (int i = 0; i < n; i++) begin
      @(negedge clk125);
      rd_tvalid = 1'b1;
      for (int j = 0; j < 4; j++) begin
        rd_tdata[32*j +: 32] = first + 4 * i + j;
      end
      rd_tlast = (i == n - 1);
      do @(posedge clk125); while (!rd_tready);
    end
    @(negedge clk125);
    rd_tvalid = 1'b0;
  endtask

  task automatic request_fill();
    @(negedge clk125);
    readout_req = 1'b1;
    do @(negedge clk125); while (!fill_done);
    readout_req = 1'b0;   // dropped while fill_done is up
  endtask

  task automatic pause_window(input int len);
    @(negedge clk125);
    readout_pause = 1'b1;
    for (int k = 1; k <= len; k++) begin
      @(negedge clk125);
      if (k >= 3) check_valid(tx_tvalid, 1'b0);   // sync delay has passed
    end
    readout_pause = 1'b0;
  endtask

  task automatic master_pulse(input int len);
    if (len >= wfd_channel_pkg::LONG_RESET_CYCLES) begin
      @(negedge clk125);
      rst_from_master = 1'b1;
      repeat (len) @(negedge clk125);
      rst_from_master = 1'b0;
      repeat (2) @(negedge clk125);    // release still in the synchronizer
      expect_cmd(1, 32'hb0000100);
      fork
        send_cmd(1, 32'hb0000100);     // offered from the first full reset cycle
        begin
          @(negedge clk125);
          repeat (wfd_channel_pkg::FULL_RESET_CYCLES - 1) begin
            @(negedge clk125);
            check_valid(tx_tvalid, 1'b0);   // word held off through the full reset
          end
        end
      join
    end else begin
      expect_cmd(4, 32'hb0000000);
      fork
        send_cmd(4, 32'hb0000000);     // stream keeps moving across a short pulse
        begin
          @(negedge clk125);
          rst_from_master = 1'b1;
          repeat (len) @(negedge clk125);
          rst_from_master = 1'b0;
          repeat (6) @(negedge clk125);
        end
      join
    end
  endtask

  task automatic drain();
    do @(negedge clk125); while (exp_data.size() != 0);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // link monitor
  always @(posedge clk125) begin
    if (!reset) begin
      check_done(fill_done, fill_due);   // one cycle after a fill's final word
    end
    fill_due = 1'b0;
    if (!reset && tx_tvalid && tx_tready) begin
      if (exp_data.size() == 0) begin
        $display("unexpected word %h on the link at %0t ns", tx_tdata, $time);
        $display("TESTS FAILED");
        $fatal(1, "scoreboard empty");
      end else begin
        fill_due = exp_end.pop_front();
        check_word(tx_tdata, tx_tlast, exp_data.pop_front(), exp_last.pop_front());
      end
    end
  end

  always @(negedge clk125) tx_tready <= (($random(seed) & 3) != 0);

  // run limit
  always @(posedge clk125) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout, the run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    int          fd;
    int          total;
    byte         op;
    logic [31:0] a, b, c, d;
    string       line;
    seed = 45366;
    cycles = 0;
    limit = 1000000;
    total = 0;
    fill_due = 1'b0;
    reset = 1'b1;
    readout_req = 1'b0;
    readout_pause = 1'b0;
    rst_from_master = 1'b0;
    cmd_tdata = '0;
    cmd_tvalid = 1'b0;
    cmd_tlast = 1'b0;
    rd_tdata = '0;
    rd_tvalid = 1'b0;
    rd_tlast = 1'b0;
    tx_tready = 1'b0;
    fd = $fopen("dv/tests_channel_tx.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/tests_channel_tx.txt");
      $display("TESTS FAILED");
      $fatal(1, "no test file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;   // blank or comment
      a = 0;
      b = 0;
      c = 0;
      d = 0;
      void'($sscanf(line, "%c %h %h %h %h", op, a, b, c, d));
      op_code.push_back(op);
      op_a.push_back(a);
      op_b.push_back(b);
      op_c.push_back(c);
      op_d.push_back(d);
      case (op)
        "C": total += a;
        "R": total += 4 * a;
        "M": total += a + 4 * c;
        "D": total += 4 * a + c;
        "P": total += 4 * b;
        default: ;
      endcase
    end
    $fclose(fd);
    limit = 20 * total + 500;
    repeat (2) @(posedge clk125);
    @(negedge clk125);
    reset = 1'b0;
    repeat (4) @(negedge clk125);   // pause synchronizer clears
    for (int i = 0; i < op_code.size(); i++) begin
      a = op_a[i];
      b = op_b[i];
      c = op_c[i];
      d = op_d[i];
      case (op_code[i])
        "C": begin
          expect_cmd(a, b);
          send_cmd(a, b);
        end
        "R": begin
          expect_fill(a, b);
          fork
            request_fill();
            send_fill(a, b);
          join
        end
        "M": begin   // request raised inside a command packet
          expect_cmd(a, b);
          expect_fill(c, d);
          fork
            send_cmd(a, b);
            begin
              do @(posedge clk125); while (!(cmd_tvalid && cmd_tready));
              request_fill();
            end
            send_fill(c, d);
          join
        end
        "D": begin   // commands offered while the readout owns the link
          expect_fill(a, b);
          expect_cmd(c, d);
          fork
            request_fill();
            send_fill(a, b);
            begin
              do @(negedge clk125); while (!dut.use_readout);
              send_cmd(c, d);
            end
          join
        end
        "P": begin
          expect_fill(b, c);
          fork
            pause_window(a);
            request_fill();
            send_fill(b, c);
          join
        end
        "T": master_pulse(a);
        "F": check_fill(fill_num, wfd_channel_pkg::fill_num_t'(a));
        default: begin
          $display("unknown operation in the test file");
          $display("TESTS FAILED");
          $fatal(1, "bad operation");
        end
      endcase
      drain();
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tests_channel_tx.txt
# op a b c d, all operands hex. C=cmd(n,first) R=fill(bursts,first) F=expect fill_num
# M=cmd(n,first)+mid request fill(bursts,first) D=fill+cmd during it P=pause(len,bursts,first) T=pulse(len)
C 3 a0000000
C 1 a0000010
R 2 10000000
F 1
M 4 a0000100 3 20000000
F 2
D 2 30000000 3 a0000200
F 3
P 14 2 40000000
F 4
C 2 a0000020
T 5
F 0
R 3 50000000
F 1
T 28
F 0
C 2 a0000300
R 1 60000000
F 1
M 3 a0000400 1 70000000
F 2

// File: all.f
common/wfd_channel_pkg.sv
design/readout/readout_width_converter.sv
design/readout/fill_readout_arbiter.sv
design/tx_stream_mux.sv
design/master_reset.sv
design/channel_tx_top.sv
dv/channel_tx_tb.sv

// File: Bender.yml
package:
  name: wfd_channel_tx

sources:
  - common/wfd_channel_pkg.sv
  - design/readout/readout_width_converter.sv
  - design/readout/fill_readout_arbiter.sv
  - design/tx_stream_mux.sv
  - design/master_reset.sv
  - design/channel_tx_top.sv
  - target: test
    files:
      - dv/channel_tx_tb.sv
